//--- files.f
hdl/i2c_ctrl_pkg.sv
hdl/i2c_cmd_seq.sv
hdl/i2c_byte_fifo.sv
hdl/i2c_bit_engine.sv
hdl/i2c_ctrl_top.sv
tests/tb_clk_gen.sv
tests/i2c_bus_monitor.sv
tests/tb_i2c_ctrl.sv

//--- hdl/i2c_bit_engine.sv
module i2c_bit_engine (
  input  logic                      clk,
  input  logic                      rst,

  input  i2c_ctrl_pkg::byte_entry_t ent_i,
  input  logic                      ent_valid_i,
  output logic                      ent_ready_o,

  input  logic                      scl_i,
  input  logic                      sda_i,
  output i2c_ctrl_pkg::i2c_pins_t   pins_o,

  output logic                      busy_o,
  output logic                      missed_ack_o
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_START,
    S_BIT,
    S_ACK,
    S_NEXT,
    S_SKIP,
    S_STOP
  } state_t;

  state_t      state;
  logic [15:0] qcnt;
  logic [1:0]  q;            // Quarter within the bit.
  logic [2:0]  bit_cnt;
  logic        last_q;
  logic        addr_phase_q;
  logic        nack_q;
  logic        missed_q;
  logic [7:0]  shift_q;
  logic [7:0]  data_q;       // First data byte held during the address.

  logic        running;
  logic        tick;
  logic        bit_end;
  logic        pop;
  logic        scl_high;
  logic        sda_high;

  assign running = state inside {S_START, S_BIT, S_ACK, S_STOP};
  assign tick    = running && (qcnt == i2c_ctrl_pkg::PRESCALE - 16'd1);
  assign bit_end = tick && (q == 2'd3);

  // Start only on an idle bus.
  assign ent_ready_o = ((state == S_IDLE) && scl_i && sda_i) ||
                       (state == S_NEXT) || (state == S_SKIP);
  assign pop         = ent_valid_i && ent_ready_o;

  // ***********************************************************
  // Sequencing
  // ***********************************************************
  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= S_IDLE;
      qcnt         <= 16'd0;
      q            <= 2'd0;
      bit_cnt      <= 3'd0;
      last_q       <= 1'b0;
      addr_phase_q <= 1'b0;
      nack_q       <= 1'b0;
      missed_q     <= 1'b0;
    end else begin
      if (tick) begin
        qcnt <= 16'd0;
        q    <= q + 2'd1;
      end else if (running) begin
        qcnt <= qcnt + 16'd1;
      end else begin
        qcnt <= 16'd0;
        q    <= 2'd0;
      end
      case (state)
        S_IDLE: begin
          if (pop) begin
            last_q       <= ent_i.last;
            addr_phase_q <= 1'b1;
            state        <= S_START;
          end
        end
        S_START: begin
          if (bit_end) begin
            bit_cnt <= 3'd0;
            state   <= S_BIT;
          end
        end
        S_BIT: begin
          if (bit_end) begin
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7) state <= S_ACK;
          end
        end
        S_ACK: begin
          if (tick && q == 2'd2) nack_q <= sda_i;  // Mid SCL high.
          if (bit_end) begin
            if (nack_q) begin
              missed_q <= 1'b1;
              state    <= last_q ? S_STOP : S_SKIP;
            end else if (addr_phase_q) begin
              addr_phase_q <= 1'b0;
              bit_cnt      <= 3'd0;
              state        <= S_BIT;
            end else begin
              state <= last_q ? S_STOP : S_NEXT;
            end
          end
        end
        S_NEXT: begin
          if (pop) begin
            last_q  <= ent_i.last;
            bit_cnt <= 3'd0;
            state   <= S_BIT;
          end
        end
        S_SKIP: begin
          if (pop && ent_i.last) state <= S_STOP;  // Drop rest of transaction.
        end
        S_STOP: begin
          if (bit_end) state <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_IDLE && pop) begin
      shift_q <= {ent_i.dev_addr, 1'b0};  // Write bit.
      data_q  <= ent_i.data;
    end else if (state == S_BIT && bit_end) begin
      shift_q <= {shift_q[6:0], 1'b0};
    end else if (state == S_ACK && bit_end && addr_phase_q && !nack_q) begin
      shift_q <= data_q;
    end else if (state == S_NEXT && pop) begin
      shift_q <= ent_i.data;
    end
  end

  // ***********************************************************
  // Line levels
  // ***********************************************************
  always_comb begin
    scl_high = 1'b1;
    sda_high = 1'b1;
    case (state)
      S_START: begin
        scl_high = (q != 2'd3);
        sda_high = (q == 2'd0);  // SDA falls with SCL high.
      end
      S_BIT: begin
        scl_high = (q == 2'd1) || (q == 2'd2);
        sda_high = shift_q[7];
      end
      S_ACK: begin
        scl_high = (q == 2'd1) || (q == 2'd2);
      end
      S_NEXT, S_SKIP: begin
        scl_high = 1'b0;
      end
      S_STOP: begin
        scl_high = (q != 2'd0);
        sda_high = q[1];  // SDA rises with SCL high.
      end
      default: begin
        scl_high = 1'b1;
        sda_high = 1'b1;
      end
    endcase
  end

  assign pins_o.scl_o  = 1'b0;
  assign pins_o.scl_t  = scl_high;
  assign pins_o.sda_o  = 1'b0;
  assign pins_o.sda_t  = sda_high;
  assign busy_o        = (state != S_IDLE);
  assign missed_ack_o  = missed_q;

  // Outside start and stop, SDA moves only inside a low SCL phase.
  assert property (@(posedge clk) disable iff (rst)
    $changed(pins_o.sda_t) && !($past(state) inside {S_START, S_STOP}) |->
      !pins_o.scl_t && !$past(pins_o.scl_t));

  // Only the entry that opens a transaction starts one.
  assert property (@(posedge clk) disable iff (rst)
    pop |-> ent_i.first == (state == S_IDLE));

endmodule

//--- hdl/i2c_byte_fifo.sv
module i2c_byte_fifo (
  input  logic                      clk,
  input  logic                      rst,

  input  i2c_ctrl_pkg::byte_entry_t wr_i,
  input  logic                      wr_valid_i,
  output logic                      wr_ready_o,

  output i2c_ctrl_pkg::byte_entry_t rd_o,
  output logic                      rd_valid_o,
  input  logic                      rd_ready_i
);

  i2c_ctrl_pkg::byte_entry_t mem [i2c_ctrl_pkg::FIFO_DEPTH];

  logic [i2c_ctrl_pkg::FIFO_AW-1:0] wr_ptr;
  logic [i2c_ctrl_pkg::FIFO_AW-1:0] rd_ptr;
  logic [i2c_ctrl_pkg::FIFO_AW:0]   count;
  logic                             do_push;
  logic                             do_pop;

  assign wr_ready_o = int'(count) < i2c_ctrl_pkg::FIFO_DEPTH;
  assign rd_valid_o = (count != '0);
  assign rd_o       = mem[rd_ptr];

  assign do_push = wr_valid_i && wr_ready_o;
  assign do_pop  = rd_valid_o && rd_ready_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;  // Wraps at depth.
      if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= wr_i;
  end

  // Count stays between empty and full.
  assert property (@(posedge clk) disable iff (rst)
    int'(count) <= i2c_ctrl_pkg::FIFO_DEPTH);

  // Count agrees with the pointer distance.
  assert property (@(posedge clk) disable iff (rst)
    count[i2c_ctrl_pkg::FIFO_AW-1:0] == wr_ptr - rd_ptr);

endmodule

//--- hdl/i2c_cmd_seq.sv
module i2c_cmd_seq (
  input  logic                      clk,
  input  logic                      rst,

  input  logic [5:0]                cmd_addr_i,
  input  i2c_ctrl_pkg::host_cmd_u   cmd_data_i,
  input  logic                      cmd_rqst_i,
  output logic                      cmd_ack_o,

  output i2c_ctrl_pkg::byte_entry_t ent_o,
  output logic                      ent_valid_o,
  input  logic                      ent_ready_i
);

  typedef enum logic {
    S_IDLE,
    S_EMIT
  } state_t;

  state_t          state;
  logic [1:0]      idx_q;       // Entry being offered.
  logic [1:0]      last_idx_q;
  logic [6:0]      filt_sel_q;  // Current filter selection.
  logic            ack_q;

  logic [6:0]      dev_q;
  logic [2:0][7:0] bytes_q;

  logic            raw_hit;
  logic            filt_req;
  logic            filt_hit;
  logic            push;

  // ***********************************************************
  // Request decode
  // ***********************************************************
  assign raw_hit  = cmd_rqst_i && (cmd_addr_i == i2c_ctrl_pkg::REG_RAW) &&
                    (cmd_data_i.raw.tag == i2c_ctrl_pkg::RAW_TAG);
  assign filt_req = cmd_rqst_i && (cmd_addr_i == i2c_ctrl_pkg::REG_FILTER);
  assign filt_hit = filt_req && (cmd_data_i.filt.select != filt_sel_q);

  assign push = ent_valid_o && ent_ready_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= S_IDLE;
      idx_q      <= 2'd0;
      last_idx_q <= 2'd0;
      filt_sel_q <= 7'd0;
      ack_q      <= 1'b0;
    end else begin
      ack_q <= 1'b0;
      case (state)
        S_IDLE: begin
          idx_q <= 2'd0;
          if (filt_req) begin
            filt_sel_q <= cmd_data_i.filt.select;
          end
          if (raw_hit) begin
            ack_q      <= 1'b1;
            last_idx_q <= 2'd1;  // Two data bytes.
            state      <= S_EMIT;
          end else if (filt_hit) begin
            ack_q      <= 1'b1;
            last_idx_q <= 2'd2;  // Register, select, zero.
            state      <= S_EMIT;
          end
        end
        S_EMIT: begin
          if (push) begin
            if (idx_q == last_idx_q) begin
              state <= S_IDLE;
            end else begin
              idx_q <= idx_q + 2'd1;
            end
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_IDLE) begin
      if (raw_hit) begin
        dev_q   <= cmd_data_i.raw.dev_addr;
        bytes_q <= {8'h00, cmd_data_i.raw.data1, cmd_data_i.raw.data0};
      end else if (filt_hit) begin
        dev_q   <= i2c_ctrl_pkg::FILT_DEV;
        bytes_q <= {8'h00, {1'b0, cmd_data_i.filt.select}, i2c_ctrl_pkg::FILT_REG};
      end
    end
  end

  // ***********************************************************
  // Entry stream
  // ***********************************************************
  assign ent_o.dev_addr = dev_q;
  assign ent_o.data     = bytes_q[idx_q];
  assign ent_o.first    = (idx_q == 2'd0);
  assign ent_o.last     = (idx_q == last_idx_q);
  assign ent_valid_o    = (state == S_EMIT);
  assign cmd_ack_o      = ack_q;

  // Offered entry holds until the FIFO takes it.
  assert property (@(posedge clk) disable iff (rst)
    ent_valid_o && !ent_ready_i |=> ent_valid_o && $stable(ent_o));

endmodule

//--- hdl/i2c_ctrl_pkg.sv
package i2c_ctrl_pkg;

  // ***********************************************************
  // Register map and fixed command values
  // ***********************************************************
  localparam logic [5:0] REG_RAW    = 6'h3d;
  localparam logic [5:0] REG_FILTER = 6'h00;
  localparam logic [7:0] RAW_TAG    = 8'h06;

  localparam logic [6:0] FILT_DEV = 7'h20;  // Filter chip address.
  localparam logic [7:0] FILT_REG = 8'h0a;  // Filter select register.

  // ***********************************************************
  // Timing and buffering
  // ***********************************************************
  localparam logic [15:0] PRESCALE = 16'd4;  // Clk cycles per quarter SCL.
  localparam int FIFO_DEPTH = 8;
  localparam int FIFO_AW    = 3;

  // ***********************************************************
  // Host command word, two views of the same 32 bits
  // ***********************************************************
  typedef struct packed {
    logic [7:0] tag;
    logic       pad;
    logic [6:0] dev_addr;
    logic [7:0] data0;
    logic [7:0] data1;
  } raw_cmd_t;

  typedef struct packed {
    logic [7:0]  pad_hi;
    logic [6:0]  select;  // Bits 23:17.
    logic [16:0] pad_lo;
  } filt_cmd_t;

  typedef union packed {
    raw_cmd_t  raw;
    filt_cmd_t filt;
  } host_cmd_u;

  typedef struct packed {
    logic [6:0] dev_addr;
    logic [7:0] data;
    logic       first;  // Begins a transaction.
    logic       last;   // Ends with a stop.
  } byte_entry_t;

  // A t bit of 1 releases the line.
  typedef struct packed {
    logic scl_o;
    logic scl_t;
    logic sda_o;
    logic sda_t;
  } i2c_pins_t;

endpackage

//--- hdl/i2c_ctrl_top.sv
module i2c_ctrl_top (
  input  logic                    clk,
  input  logic                    rst,

  input  logic [5:0]              cmd_addr_i,
  input  i2c_ctrl_pkg::host_cmd_u cmd_data_i,
  input  logic                    cmd_rqst_i,
  output logic                    cmd_ack_o,

  input  logic                    scl_i,
  input  logic                    sda_i,
  output i2c_ctrl_pkg::i2c_pins_t pins_o,

  output logic                    busy_o,
  output logic                    missed_ack_o
);

  i2c_ctrl_pkg::byte_entry_t seq_ent;
  logic                      seq_valid;
  logic                      seq_ready;

  i2c_ctrl_pkg::byte_entry_t fifo_ent;
  logic                      fifo_valid;
  logic                      fifo_ready;

  i2c_cmd_seq u_seq (
    .clk         (clk),
    .rst         (rst),
    .cmd_addr_i  (cmd_addr_i),
    .cmd_data_i  (cmd_data_i),
    .cmd_rqst_i  (cmd_rqst_i),
    .cmd_ack_o   (cmd_ack_o),
    .ent_o       (seq_ent),
    .ent_valid_o (seq_valid),
    .ent_ready_i (seq_ready)
  );

  i2c_byte_fifo u_fifo (
    .clk        (clk),
    .rst        (rst),
    .wr_i       (seq_ent),
    .wr_valid_i (seq_valid),
    .wr_ready_o (seq_ready),
    .rd_o       (fifo_ent),
    .rd_valid_o (fifo_valid),
    .rd_ready_i (fifo_ready)
  );

  i2c_bit_engine u_engine (
    .clk          (clk),
    .rst          (rst),
    .ent_i        (fifo_ent),
    .ent_valid_i  (fifo_valid),
    .ent_ready_o  (fifo_ready),
    .scl_i        (scl_i),
    .sda_i        (sda_i),
    .pins_o       (pins_o),
    .busy_o       (busy_o),
    .missed_ack_o (missed_ack_o)
  );

endmodule

//--- run_sim.sh
#!/bin/sh
# Builds the I2C controller testbench with Verilator, runs it and scans the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_LOG=build.log
OBJ=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module tb_i2c_ctrl -f files.f --Mdir "$OBJ" -o sim_tb > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "sim failed" "$LOG"; then
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
exit 0

//--- tests/i2c_bus_monitor.sv
module i2c_bus_monitor (
  input  logic            rst_i,
  input  logic            scl_i,
  input  logic            sda_i,
  input  logic            nack_en_i,
  output logic            sda_o,
  output int              rx_count_o,
  output int              rx_len_o,
  output logic [3:0][7:0] rx_bytes_o
);
  timeunit 1ns;
  timeprecision 1ns;

  logic       scl_prev;
  logic       sda_prev;
  logic       in_txn;
  int         bit_cnt;
  int         i;
  logic [7:0] shift;
  logic [7:0] cur_q [$];

  always begin
    if (rst_i) begin
      in_txn     = 1'b0;
      bit_cnt    = 0;
      shift      = 8'h00;
      sda_o      = 1'b1;
      rx_count_o = 0;
      rx_len_o   = 0;
      rx_bytes_o = '0;
    end else if (scl_i && scl_prev && sda_prev && !sda_i) begin
      in_txn  = 1'b1;  // Start.
      bit_cnt = 0;
      cur_q.delete();
    end else if (scl_i && scl_prev && !sda_prev && sda_i) begin
      if (in_txn) begin  // Stop closes the transaction.
        rx_len_o   = cur_q.size();
        rx_bytes_o = '0;
        for (i = 0; i < 4; i++) begin
          if (i < cur_q.size()) rx_bytes_o[i[1:0]] = cur_q[i];
        end
        rx_count_o++;
      end
      in_txn = 1'b0;
      sda_o  = 1'b1;
    end else if (in_txn && scl_i && !scl_prev) begin
      if (bit_cnt < 8) begin
        shift = {shift[6:0], sda_i};  // MSB first.
        bit_cnt++;
        if (bit_cnt == 8) cur_q.push_back(shift);
      end else begin
        bit_cnt = 0;  // ACK clock.
      end
    end else if (in_txn && !scl_i && scl_prev) begin
      sda_o = !((bit_cnt == 8) && !nack_en_i);  // Hold low through the ACK bit.
    end
    scl_prev = scl_i;
    sda_prev = sda_i;
    @(scl_i or sda_i or rst_i);
  end

endmodule

//--- tests/tb_clk_gen.sv
module tb_clk_gen (
  output logic clk_o,
  output logic rst_o
);
  timeunit 1ns;
  timeprecision 1ns;

  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;  // 100 ns period.
  end

  initial begin
    rst_o = 1'b1;
    repeat (10) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;
  end

endmodule

//--- tests/tb_i2c_ctrl.sv
module tb_i2c_ctrl;
  timeunit 1ns;
  timeprecision 1ns;

  localparam int NUM_CMDS        = 40;
  localparam int BIT_CYCLES      = 4 * int'(i2c_ctrl_pkg::PRESCALE);
  localparam int WATCHDOG_CYCLES = (NUM_CMDS + 4) * 4 * 9 * BIT_CYCLES * 2;
  localparam int ACK_WAIT_CYCLES = 10000;
  localparam int DRAIN_CYCLES    = 20000;

  logic                    clk;
  logic                    rst;
  logic [5:0]              cmd_addr;
  i2c_ctrl_pkg::host_cmd_u cmd_data;
  logic                    cmd_rqst;
  logic                    cmd_ack;
  i2c_ctrl_pkg::i2c_pins_t dut_pins;
  logic                    busy;
  logic                    missed_ack;
  logic                    scl_bus;
  logic                    sda_bus;
  logic                    mon_sda;
  logic                    nack_en;
  int                      rx_count;
  int                      rx_len;
  logic [3:0][7:0]         rx_bytes;
  int                      rx_seen;
  int                      seed;
  logic [6:0]              model_sel;

  logic [6:0] exp_dev_q [$];
  int         exp_len_q [$];
  logic [7:0] exp_byte_q [$];

  tb_clk_gen u_clk (
    .clk_o (clk),
    .rst_o (rst)
  );

  i2c_ctrl_top u_dut (
    .clk          (clk),
    .rst          (rst),
    .cmd_addr_i   (cmd_addr),
    .cmd_data_i   (cmd_data),
    .cmd_rqst_i   (cmd_rqst),
    .cmd_ack_o    (cmd_ack),
    .scl_i        (scl_bus),
    .sda_i        (sda_bus),
    .pins_o       (dut_pins),
    .busy_o       (busy),
    .missed_ack_o (missed_ack)
  );

  i2c_bus_monitor u_mon (
    .rst_i      (rst),
    .scl_i      (scl_bus),
    .sda_i      (sda_bus),
    .nack_en_i  (nack_en),
    .sda_o      (mon_sda),
    .rx_count_o (rx_count),
    .rx_len_o   (rx_len),
    .rx_bytes_o (rx_bytes)
  );

  // Open-drain lines with pull-ups and wired-AND on SDA.
  assign scl_bus = dut_pins.scl_t ? 1'b1 : dut_pins.scl_o;
  assign sda_bus = (dut_pins.sda_t ? 1'b1 : dut_pins.sda_o) & mon_sda;

  // ***********************************************************
  // Checking
  // ***********************************************************
  task automatic abort_run();
    $display("sim failed");
    $fatal(1, "first error ends the run");
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("FAIL %s got 0x%02h expected 0x%02h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_dev(input string name, input logic [6:0] got, input logic [6:0] exp);
    if (got !== exp) begin
      $display("FAIL %s got 0x%02h expected 0x%02h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic expect_txn(input logic [6:0] dev, input int n, input logic [7:0] b0,
                            input logic [7:0] b1, input logic [7:0] b2);
    exp_dev_q.push_back(dev);
    exp_len_q.push_back(n);
    if (n > 0) exp_byte_q.push_back(b0);
    if (n > 1) exp_byte_q.push_back(b1);
    if (n > 2) exp_byte_q.push_back(b2);
  endtask

  task automatic check_txn();
    logic [6:0] dev;
    int         n;
    int         i;
    rx_seen++;
    check_flag("busy_o", busy, 1'b1);  // Stop still in progress.
    if (exp_dev_q.size() == 0) begin
      $display("a transaction arrived on the bus when none was expected");
      abort_run();
    end else begin
      dev = exp_dev_q.pop_front();
      n   = exp_len_q.pop_front();
      check_byte("rx_len", 8'(rx_len), 8'(n + 1));  // Address byte counts too.
      check_dev("rx_dev_addr", rx_bytes[0][7:1], dev);
      check_flag("rx_rw_bit", rx_bytes[0][0], 1'b0);
      for (i = 0; i < n; i++) begin
        check_byte("rx_data", rx_bytes[i[1:0] + 2'd1], exp_byte_q.pop_front());
      end
    end
  endtask

  always @(negedge clk) begin
    if (!rst && rx_count != rx_seen) check_txn();
  end

  // ***********************************************************
  // Host side
  // ***********************************************************
  task automatic send_cmd(input logic [5:0] addr, input i2c_ctrl_pkg::host_cmd_u data,
                          input logic accept);
    int   waited;
    logic taking;
    waited   = 0;
    taking   = 1'b0;
    cmd_addr = addr;
    cmd_data = data;
    cmd_rqst = 1'b1;
    if (accept) begin
      while (!taking) begin
        taking = !u_dut.seq_valid;  // Idle sequencer takes it at the next edge.
        @(negedge clk);
        check_flag("cmd_ack_o", cmd_ack, taking);
        waited++;
        if (waited > ACK_WAIT_CYCLES) begin
          $display("an accepted command was never acknowledged");
          abort_run();
        end
      end
      cmd_rqst = 1'b0;
      @(negedge clk);
      check_flag("cmd_ack_o", cmd_ack, 1'b0);  // One-cycle pulse.
    end else begin
      repeat (4) begin
        @(negedge clk);
        check_flag("cmd_ack_o", cmd_ack, 1'b0);
      end
      cmd_rqst = 1'b0;
    end
  endtask

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    while (exp_dev_q.size() != 0 || busy) begin
      @(negedge clk);
      cycles++;
      if (cycles > DRAIN_CYCLES) begin
        $display("bus still busy long after the last command");
        abort_run();
      end
    end
  endtask

  initial begin
    #(WATCHDOG_CYCLES * 100);
    $display("watchdog expired before the test sequence finished");
    abort_run();
  end

  // ***********************************************************
  // Stimulus
  // ***********************************************************
  initial begin
    logic [31:0]             r;
    i2c_ctrl_pkg::host_cmd_u cmd;
    logic [5:0]              addr;
    logic [2:0]              kind;
    logic                    accept;
    int                      gap;
    int                      k;
    seed      = 32'hdef4a256;
    cmd_addr  = 6'd0;
    cmd_data  = '0;
    cmd_rqst  = 1'b0;
    nack_en   = 1'b0;
    model_sel = 7'd0;
    rx_seen   = 0;
    @(negedge rst);
    @(negedge clk);
    check_flag("cmd_ack_o", cmd_ack, 1'b0);
    check_flag("scl_t", dut_pins.scl_t, 1'b1);
    check_flag("sda_t", dut_pins.sda_t, 1'b1);
    check_flag("busy_o", busy, 1'b0);
    check_flag("missed_ack_o", missed_ack, 1'b0);

    for (k = 0; k < NUM_CMDS; k++) begin
      r      = $random(seed);
      cmd    = $random(seed);
      kind   = r[2:0];
      accept = 1'b0;
      addr   = i2c_ctrl_pkg::REG_RAW;
      case (kind)
        3'd3, 3'd4: begin
          addr            = i2c_ctrl_pkg::REG_FILTER;
          cmd.filt.select = {5'd0, r[9:8]};  // Small range so repeats occur.
          if (cmd.filt.select != model_sel) begin
            accept    = 1'b1;
            model_sel = cmd.filt.select;
            expect_txn(i2c_ctrl_pkg::FILT_DEV, 3, i2c_ctrl_pkg::FILT_REG,
                       {1'b0, model_sel}, 8'h00);
          end
        end
        3'd5: begin
          if (cmd.raw.tag == i2c_ctrl_pkg::RAW_TAG) cmd.raw.tag = 8'h60;
        end
        3'd6: begin
          addr = r[21:16];
          if (addr == i2c_ctrl_pkg::REG_RAW || addr == i2c_ctrl_pkg::REG_FILTER) begin
            addr = 6'h15;
          end
        end
        default: begin
          cmd.raw.tag = i2c_ctrl_pkg::RAW_TAG;
          accept      = 1'b1;
          expect_txn(cmd.raw.dev_addr, 2, cmd.raw.data0, cmd.raw.data1, 8'h00);
        end
      endcase
      send_cmd(addr, cmd, accept);
      gap = (r[14:12] == 3'd0) ? int'(r[31:24]) : 0;  // Mostly back-to-back bursts.
      repeat (gap) @(negedge clk);
    end
    wait_idle();
    check_flag("missed_ack_o", missed_ack, 1'b0);

    // On an address NACK only the address byte reaches the bus.
    nack_en     = 1'b1;
    cmd         = $random(seed);
    cmd.raw.tag = i2c_ctrl_pkg::RAW_TAG;
    expect_txn(cmd.raw.dev_addr, 0, 8'h00, 8'h00, 8'h00);
    send_cmd(i2c_ctrl_pkg::REG_RAW, cmd, 1'b1);
    wait_idle();
    nack_en = 1'b0;
    check_flag("missed_ack_o", missed_ack, 1'b1);

    cmd         = $random(seed);
    cmd.raw.tag = i2c_ctrl_pkg::RAW_TAG;
    expect_txn(cmd.raw.dev_addr, 2, cmd.raw.data0, cmd.raw.data1, 8'h00);
    send_cmd(i2c_ctrl_pkg::REG_RAW, cmd, 1'b1);
    wait_idle();
    check_flag("missed_ack_o", missed_ack, 1'b1);  // Sticky.

    $display("sim passed");
    $finish;
  end

endmodule
